// File: rtl/jvs_consts.svh
// JVS protocol byte codes, buffer depth and RS485 direction timing
`ifndef JVS_CONSTS_SVH
`define JVS_CONSTS_SVH

////////////////////
// Frame byte codes
////////////////////

`define JVS_SYNC     8'hE0 // Start of frame, never escaped
`define JVS_ESCAPE   8'hD0 // Escape prefix
`define JVS_ESC_SYNC 8'hDF // D0 DF stands for E0
`define JVS_ESC_ESC  8'hCF // D0 CF stands for D0

////////////////////
// Sizes
////////////////////

`define JVS_BUFFER_DEPTH  256 // Data bytes per frame buffer
`define JVS_CHECKSUM_SIZE 1   // Checksum share of the length field

////////////////////
// RS485 direction
////////////////////

// Clocks at 50 MHz
`define JVS_RS485_SETUP_CYCLES 500  // 10 us of drive before the sync byte
`define JVS_RS485_HOLD_CYCLES  1500 // 30 us of drive after the checksum

`endif

// File: rtl/jvs_pkg.sv
// Shared byte, count, status and FSM state types for the JVS link
package jvs_pkg;

    typedef logic [7:0] jvs_byte_t; // One protocol byte
    typedef logic [7:0] jvs_len_t;  // Length field, index or counter

    // STATUS codes, first data byte of a reply
    typedef enum logic [7:0] {
        status_normal       = 8'h01,
        status_unknown_cmd  = 8'h02,
        status_sum_error    = 8'h03,
        status_ack_overflow = 8'h04,
        status_busy         = 8'h05
    } jvs_status_e;

    // Receive parser
    typedef enum logic [2:0] {
        RX_IDLE, RX_NODE, RX_LENGTH, RX_DATA, RX_VALIDATE
    } rx_state_e;

    // Transmit sequencer, TX_WAIT is the shared byte handshake
    typedef enum logic [3:0] {
        TX_IDLE, TX_SETUP, TX_SYNC, TX_NODE, TX_LENGTH,
        TX_DATA, TX_CHECKSUM, TX_WAIT, TX_HOLD
    } tx_state_e;

endpackage

// File: rtl/jvs_rx_unescape.sv
// RX byte unescaper producing decoded bytes and a frame start flag
`include "jvs_consts.svh"

module jvs_rx_unescape (
    input  logic              clk_sys,
    input  logic              reset,
    input  logic              i_raw_valid, // One cycle per byte from UART
    input  jvs_pkg::jvs_byte_t i_raw_byte,
    output logic              o_dec_valid,
    output logic              o_dec_start, // Raw E0 seen
    output jvs_pkg::jvs_byte_t o_dec_byte
);

    logic esc_mode; // Previous byte was D0

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            esc_mode    <= 1'b0;
            o_dec_valid <= 1'b0;
            o_dec_start <= 1'b0;
        end else begin
            o_dec_valid <= 1'b0;
            o_dec_start <= 1'b0;
            if (i_raw_valid) begin
                if (i_raw_byte == `JVS_SYNC) begin
                    o_dec_start <= 1'b1; // Sync wins over a pending escape
                    esc_mode    <= 1'b0;
                end else if (esc_mode) begin
                    esc_mode    <= 1'b0;  // Bad pair is dropped silently
                    o_dec_valid <= (i_raw_byte == `JVS_ESC_SYNC) ||
                                   (i_raw_byte == `JVS_ESC_ESC);
                end else if (i_raw_byte == `JVS_ESCAPE) begin
                    esc_mode <= 1'b1;     // Prefix alone gives no output
                end else begin
                    o_dec_valid <= 1'b1;
                end
            end
        end
    end

    // Decoded value, only looked at with o_dec_valid
    always_ff @(posedge clk_sys) begin
        if (i_raw_valid) begin
            if (!esc_mode) o_dec_byte <= i_raw_byte;
            else o_dec_byte <= (i_raw_byte == `JVS_ESC_SYNC) ? `JVS_SYNC : `JVS_ESCAPE;
        end
    end

endmodule

// File: rtl/jvs_rx_frame.sv
// RX frame parser with checksum check, buffer writes and error counter
`include "jvs_consts.svh"

module jvs_rx_frame (
    input  logic              clk_sys,
    input  logic              reset,
    input  logic              i_dec_valid,
    input  logic              i_dec_start,
    input  jvs_pkg::jvs_byte_t i_dec_byte,
    output logic              o_wr_en,      // Buffer write strobe
    output jvs_pkg::jvs_len_t  o_wr_addr,
    output jvs_pkg::jvs_byte_t o_wr_byte,
    output logic              o_load,       // Good frame in buffer
    output jvs_pkg::jvs_len_t  o_length,     // Data byte count, checksum excluded
    output jvs_pkg::jvs_byte_t o_src_node,
    output logic              o_rx_error,
    output jvs_pkg::jvs_len_t  o_checksum_errors
);

    jvs_pkg::rx_state_e state;
    jvs_pkg::jvs_len_t  idx;      // Data bytes taken so far
    jvs_pkg::jvs_len_t  len;      // Length field as received
    jvs_pkg::jvs_byte_t sum;      // Running sum of node, length, data
    jvs_pkg::jvs_byte_t recv_sum; // Checksum byte from the line
    logic               err_pend; // Mismatch, reported one clock later to line up with complete

    ////////////////////
    // Control
    ////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state             <= jvs_pkg::RX_IDLE;
            idx               <= '0;
            o_wr_en           <= 1'b0;
            o_load            <= 1'b0;
            err_pend          <= 1'b0;
            o_rx_error        <= 1'b0;
            o_checksum_errors <= '0;
        end else begin
            o_wr_en    <= 1'b0;
            o_load     <= 1'b0;
            err_pend   <= 1'b0;
            o_rx_error <= err_pend;
            if (err_pend) o_checksum_errors <= o_checksum_errors + 8'd1;

            // Decision cycle, may overlap a new sync
            if (state == jvs_pkg::RX_VALIDATE) begin
                o_load   <= (sum == recv_sum);
                err_pend <= (sum != recv_sum);
                state    <= jvs_pkg::RX_IDLE;
            end

            if (i_dec_start) begin
                state <= jvs_pkg::RX_NODE; // Restart from any state
                idx   <= '0;
            end else if (i_dec_valid) begin
                case (state)
                    jvs_pkg::RX_NODE:   state <= jvs_pkg::RX_LENGTH;
                    jvs_pkg::RX_LENGTH: begin
                        // Zero length cannot hold a checksum
                        state <= (i_dec_byte == 8'd0) ? jvs_pkg::RX_IDLE : jvs_pkg::RX_DATA;
                    end
                    jvs_pkg::RX_DATA: begin
                        if (idx == len - 8'd1) begin
                            state <= jvs_pkg::RX_VALIDATE; // Last byte is the checksum
                        end else begin
                            o_wr_en <= 1'b1;
                            idx     <= idx + 8'd1;
                        end
                    end
                    default: ; // Stray bytes outside a frame
                endcase
            end
        end
    end

    ////////////////////
    // Datapath
    ////////////////////

    always_ff @(posedge clk_sys) begin
        if (i_dec_start) sum <= '0;
        else if (i_dec_valid) begin
            case (state)
                jvs_pkg::RX_NODE: begin
                    o_src_node <= i_dec_byte;
                    sum        <= sum + i_dec_byte;
                end
                jvs_pkg::RX_LENGTH: begin
                    len <= i_dec_byte;
                    sum <= sum + i_dec_byte;
                end
                jvs_pkg::RX_DATA: begin
                    if (idx == len - 8'd1) recv_sum <= i_dec_byte;
                    else sum <= sum + i_dec_byte;
                    o_wr_addr <= idx;
                    o_wr_byte <= i_dec_byte;
                end
                default: ;
            endcase
        end
        if (state == jvs_pkg::RX_VALIDATE) o_length <= jvs_pkg::jvs_len_t'(len - `JVS_CHECKSUM_SIZE);
    end

endmodule

// File: rtl/jvs_rx_buffer.sv
// RX frame storage with STATUS split and sequential host read-out
`include "jvs_consts.svh"

module jvs_rx_buffer (
    input  logic                clk_sys,
    input  logic                reset,
    input  logic                i_wr_en,
    input  logic                i_load,    // Frame passed its checksum
    input  jvs_pkg::jvs_len_t    i_wr_addr,
    input  jvs_pkg::jvs_len_t    i_length,  // Data bytes, STATUS included
    input  jvs_pkg::jvs_byte_t   i_wr_byte,
    input  logic                i_rx_next,
    output logic                o_rx_complete,
    output jvs_pkg::jvs_status_e o_rx_status,
    output jvs_pkg::jvs_byte_t   o_rx_byte,
    output jvs_pkg::jvs_len_t    o_rx_remaining // Bytes after o_rx_byte
);

    jvs_pkg::jvs_byte_t mem [`JVS_BUFFER_DEPTH];
    jvs_pkg::jvs_len_t  rd_idx; // Entry shown on o_rx_byte
    logic               step;

    assign step = i_rx_next && (o_rx_remaining != 8'd0);

    always_ff @(posedge clk_sys) begin
        if (i_wr_en) mem[i_wr_addr] <= i_wr_byte;
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            o_rx_complete  <= 1'b0;
            o_rx_remaining <= '0;
            rd_idx         <= '0;
        end else begin
            o_rx_complete <= i_load;
            if (i_load) begin
                rd_idx         <= 8'd1; // Entry 0 is STATUS
                o_rx_remaining <= (i_length > 8'd1) ? i_length - 8'd2 : 8'd0;
            end else if (step) begin
                rd_idx         <= rd_idx + 8'd1;
                o_rx_remaining <= o_rx_remaining - 8'd1;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (i_load) begin
            o_rx_status <= jvs_pkg::jvs_status_e'(mem[0]);
            o_rx_byte   <= mem[1];
        end else if (step) begin
            o_rx_byte <= mem[jvs_pkg::jvs_len_t'(rd_idx + 8'd1)];
        end
    end

endmodule

// File: rtl/jvs_tx_frame.sv
// TX push buffer, frame encapsulation with escaping, checksum and RS485 timing
`include "jvs_consts.svh"

module jvs_tx_frame (
    input  logic              clk_sys,
    input  logic              reset,
    input  jvs_pkg::jvs_byte_t i_tx_data,
    input  jvs_pkg::jvs_byte_t i_dst_node,
    input  logic              i_tx_push,   // Append i_tx_data
    input  logic              i_tx_commit, // Send the buffered frame
    input  logic              i_uart_tx_done,
    output logic              o_tx_ready,
    output logic              o_uart_tx_valid,
    output logic              o_rs485_dir, // High while driving the bus
    output jvs_pkg::jvs_byte_t o_uart_tx_byte
);

    jvs_pkg::tx_state_e state;
    jvs_pkg::tx_state_e tx_next;  // Where TX_WAIT returns on done
    jvs_pkg::tx_state_e after;    // State after the current field
    jvs_pkg::jvs_byte_t tx_buf [`JVS_BUFFER_DEPTH];
    jvs_pkg::jvs_len_t  count;    // Bytes pushed
    jvs_pkg::jvs_len_t  idx;      // Data byte being sent
    jvs_pkg::jvs_byte_t node;
    jvs_pkg::jvs_len_t  length;
    jvs_pkg::jvs_byte_t cksum;
    jvs_pkg::jvs_byte_t cur_val;  // Unescaped value of the current field
    logic               esc_pend; // D0 went out, code byte next
    logic [15:0]        timer;    // Setup and hold delays

    function automatic logic needs_escape(input jvs_pkg::jvs_byte_t b);
        return (b == `JVS_SYNC) || (b == `JVS_ESCAPE);
    endfunction

    function automatic jvs_pkg::jvs_byte_t escape_code(input jvs_pkg::jvs_byte_t b);
        return (b == `JVS_SYNC) ? `JVS_ESC_SYNC : `JVS_ESC_ESC;
    endfunction

    // Field value and successor per byte state
    always_comb begin
        cur_val = cksum;
        after   = jvs_pkg::TX_HOLD;
        case (state)
            jvs_pkg::TX_NODE: begin
                cur_val = node;
                after   = jvs_pkg::TX_LENGTH;
            end
            jvs_pkg::TX_LENGTH: begin
                cur_val = length;
                after   = (count == 8'd0) ? jvs_pkg::TX_CHECKSUM : jvs_pkg::TX_DATA;
            end
            jvs_pkg::TX_DATA: begin
                cur_val = tx_buf[idx];
                after   = (idx == count - 8'd1) ? jvs_pkg::TX_CHECKSUM : jvs_pkg::TX_DATA;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (i_tx_push && o_tx_ready) tx_buf[count] <= i_tx_data;
    end

    ////////////////////
    // Sequencer
    ////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state           <= jvs_pkg::TX_IDLE;
            tx_next         <= jvs_pkg::TX_IDLE;
            o_tx_ready      <= 1'b1;
            o_rs485_dir     <= 1'b0;
            o_uart_tx_valid <= 1'b0;
            count           <= '0;
            idx             <= '0;
            cksum           <= '0;
            esc_pend        <= 1'b0;
            timer           <= '0;
        end else begin
            o_uart_tx_valid <= 1'b0; // One-cycle strobe
            case (state)
                jvs_pkg::TX_IDLE: begin
                    if (i_tx_push && o_tx_ready) count <= count + 8'd1;
                    if (i_tx_commit && o_tx_ready) begin
                        node        <= i_dst_node;
                        length      <= jvs_pkg::jvs_len_t'(count + `JVS_CHECKSUM_SIZE);
                        o_tx_ready  <= 1'b0;
                        o_rs485_dir <= 1'b1; // Turn the transceiver around first
                        timer       <= '0;
                        idx         <= '0;
                        cksum       <= '0;
                        state       <= jvs_pkg::TX_SETUP;
                    end
                end
                jvs_pkg::TX_SETUP: begin
                    if (timer == 16'(`JVS_RS485_SETUP_CYCLES - 1)) state <= jvs_pkg::TX_SYNC;
                    else timer <= timer + 16'd1;
                end
                jvs_pkg::TX_SYNC: begin
                    o_uart_tx_byte  <= `JVS_SYNC; // Only unescaped byte
                    o_uart_tx_valid <= 1'b1;
                    tx_next         <= jvs_pkg::TX_NODE;
                    state           <= jvs_pkg::TX_WAIT;
                end
                jvs_pkg::TX_NODE, jvs_pkg::TX_LENGTH, jvs_pkg::TX_DATA,
                jvs_pkg::TX_CHECKSUM: begin
                    o_uart_tx_valid <= 1'b1;
                    state           <= jvs_pkg::TX_WAIT;
                    if (needs_escape(cur_val) && !esc_pend) begin
                        o_uart_tx_byte <= `JVS_ESCAPE;
                        esc_pend       <= 1'b1;
                        tx_next        <= state; // Come back for the code byte
                    end else begin
                        o_uart_tx_byte <= esc_pend ? escape_code(cur_val) : cur_val;
                        esc_pend       <= 1'b0;
                        tx_next        <= after;
                        if (state != jvs_pkg::TX_CHECKSUM) cksum <= cksum + cur_val;
                        if (state == jvs_pkg::TX_DATA) idx <= idx + 8'd1;
                    end
                end
                jvs_pkg::TX_WAIT: begin
                    // Late done just stretches the frame
                    if (i_uart_tx_done) begin
                        state <= tx_next;
                        timer <= '0;
                    end
                end
                jvs_pkg::TX_HOLD: begin
                    if (timer == 16'(`JVS_RS485_HOLD_CYCLES)) begin
                        o_rs485_dir <= 1'b0;
                        o_tx_ready  <= 1'b1;
                        count       <= '0; // Buffer emptied for the next frame
                        state       <= jvs_pkg::TX_IDLE;
                    end else begin
                        timer <= timer + 16'd1;
                    end
                end
                default: state <= jvs_pkg::TX_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/jvs_link.sv
// JVS frame layer top with TX encapsulation and RX decode, parse and buffer
module jvs_link (
    input  logic                clk_sys,
    input  logic                reset,
    // Host TX
    input  jvs_pkg::jvs_byte_t   i_tx_data,
    input  logic                i_tx_push,
    input  logic                i_tx_commit,
    input  jvs_pkg::jvs_byte_t   i_dst_node,
    output logic                o_tx_ready,
    // UART TX
    output logic                o_uart_tx_valid,
    output jvs_pkg::jvs_byte_t   o_uart_tx_byte,
    input  logic                i_uart_tx_done,
    output logic                o_rs485_dir,
    // UART RX
    input  logic                i_uart_rx_valid,
    input  jvs_pkg::jvs_byte_t   i_uart_rx_byte,
    // Host RX
    output logic                o_rx_complete,
    output jvs_pkg::jvs_status_e o_rx_status,
    output jvs_pkg::jvs_byte_t   o_rx_src_node,
    output jvs_pkg::jvs_byte_t   o_rx_byte,
    output jvs_pkg::jvs_len_t    o_rx_remaining,
    input  logic                i_rx_next,
    output logic                o_rx_error,
    output jvs_pkg::jvs_len_t    o_checksum_errors
);

    logic               dec_valid, dec_start;
    jvs_pkg::jvs_byte_t dec_byte;
    logic               wr_en, load;
    jvs_pkg::jvs_len_t  wr_addr, length;
    jvs_pkg::jvs_byte_t wr_byte;

    ////////////////////
    // RX path
    ////////////////////

    jvs_rx_unescape jvs_rx_unescape_inst (
        .clk_sys, .reset,
        .i_raw_valid (i_uart_rx_valid), .i_raw_byte (i_uart_rx_byte),
        .o_dec_valid (dec_valid), .o_dec_start (dec_start), .o_dec_byte (dec_byte)
    );

    jvs_rx_frame jvs_rx_frame_inst (
        .clk_sys, .reset,
        .i_dec_valid (dec_valid), .i_dec_start (dec_start), .i_dec_byte (dec_byte),
        .o_wr_en (wr_en), .o_wr_addr (wr_addr), .o_wr_byte (wr_byte),
        .o_load (load), .o_length (length), .o_src_node (o_rx_src_node),
        .o_rx_error, .o_checksum_errors
    );

    jvs_rx_buffer jvs_rx_buffer_inst (
        .clk_sys, .reset,
        .i_wr_en (wr_en), .i_load (load), .i_wr_addr (wr_addr),
        .i_length (length), .i_wr_byte (wr_byte), .i_rx_next,
        .o_rx_complete, .o_rx_status, .o_rx_byte, .o_rx_remaining
    );

    ////////////////////
    // TX path
    ////////////////////

    jvs_tx_frame jvs_tx_frame_inst (
        .clk_sys, .reset,
        .i_tx_data, .i_dst_node, .i_tx_push, .i_tx_commit, .i_uart_tx_done,
        .o_tx_ready, .o_uart_tx_valid, .o_rs485_dir, .o_uart_tx_byte
    );

endmodule

// File: tb/tb_jvs_link.sv
// Testbench for jvs_link with a stimulus table, UART byte responder, timing monitor and watchdog
`include "jvs_consts.svh"

module tb_jvs_link;

    localparam int CLK_PERIOD = 100;
    localparam int N_ENTRIES  = 7;
    localparam int MAX_DELAY  = 7;   // Done delay takes 3 LFSR bits
    localparam int MAX_FRAME  = 211; // Sync, node, length, 207 data bytes, checksum
    localparam int WATCHDOG_CYCLES = N_ENTRIES * (`JVS_RS485_SETUP_CYCLES +
        `JVS_RS485_HOLD_CYCLES + 2 * MAX_FRAME * (MAX_DELAY + 3));

    logic clk_sys, reset;
    logic i_tx_push, i_tx_commit, i_uart_tx_done, i_uart_rx_valid, i_rx_next;
    logic o_tx_ready, o_uart_tx_valid, o_rs485_dir, o_rx_complete, o_rx_error;
    jvs_pkg::jvs_byte_t   i_tx_data, i_dst_node, i_uart_rx_byte;
    jvs_pkg::jvs_byte_t   o_uart_tx_byte, o_rx_src_node, o_rx_byte;
    jvs_pkg::jvs_len_t    o_rx_remaining, o_checksum_errors;
    jvs_pkg::jvs_status_e o_rx_status;

    logic [55:0]        stim_tab [N_ENTRIES]; // Bad flag, node, data count, first 4 data bytes
    jvs_pkg::jvs_byte_t frame_data [`JVS_BUFFER_DEPTH];
    jvs_pkg::jvs_byte_t enc_q [$]; // Expected line bytes
    jvs_pkg::jvs_byte_t got_q [$]; // Bytes seen on o_uart_tx_valid
    logic [15:0]        lfsr;
    int                 cyc = 0;
    int                 rise_cyc = 0;
    int                 done_cyc = 0;
    logic               dir_q = 1'b0;
    logic               first_byte = 1'b0;

    jvs_link jvs_link_inst (.*);

    initial begin
        clk_sys = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) cyc <= cyc + 1; // Read only at negedge

    ////////////////////
    // Reporting
    ////////////////////

    task automatic end_with_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_failure(input string why);
        $display("%s", why);
        end_with_failure();
    endtask

    task automatic check_byte(input string name, input jvs_pkg::jvs_byte_t exp,
                              input jvs_pkg::jvs_byte_t got);
        if (got !== exp) begin
            $display("ERROR at %0t: %s expected %h got %h", $time, name, exp, got);
            end_with_failure();
        end
    endtask

    task automatic check_status(input string name, input jvs_pkg::jvs_status_e exp,
                                input jvs_pkg::jvs_status_e got);
        if (got !== exp) begin
            $display("ERROR at %0t: %s expected %h got %h", $time, name, exp, got);
            end_with_failure();
        end
    endtask

    task automatic check_count(input string name, input jvs_pkg::jvs_len_t exp,
                               input jvs_pkg::jvs_len_t got);
        if (got !== exp) begin
            $display("ERROR at %0t: %s expected %0d got %0d", $time, name, exp, got);
            end_with_failure();
        end
    endtask

    ////////////////////
    // Stimulus helpers
    ////////////////////

    // Galois LFSR, one step per bit taken
    function automatic int rand_bits(input int nbits);
        int r;
        r = 0;
        for (int i = 0; i < nbits; i++) begin
            r    = (r << 1) | lfsr[0];
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 16'hB400 : 16'h0000);
        end
        return r;
    endfunction

    task automatic build_frame(input int e, output jvs_pkg::jvs_byte_t node, output int n,
                               output logic bad);
        logic [55:0] row;
        row  = stim_tab[e];
        bad  = row[48];
        node = row[47:40];
        n    = row[39:32];
        for (int j = 0; j < n; j++) begin
            if (j < 4) frame_data[j] = row[31 - 8 * j -: 8];
            else frame_data[j] = jvs_pkg::jvs_byte_t'(rand_bits(8)); // Filler
        end
    endtask

    task automatic push_escaped(input jvs_pkg::jvs_byte_t b);
        if (b == `JVS_SYNC || b == `JVS_ESCAPE) begin
            enc_q.push_back(`JVS_ESCAPE);
            enc_q.push_back(b == `JVS_SYNC ? `JVS_ESC_SYNC : `JVS_ESC_ESC);
        end else begin
            enc_q.push_back(b);
        end
    endtask

    // Line image of a frame, sync is the only raw byte
    task automatic encode_frame(input jvs_pkg::jvs_byte_t node, input int n,
                                input logic corrupt);
        jvs_pkg::jvs_len_t  len;
        jvs_pkg::jvs_byte_t sum;
        len = jvs_pkg::jvs_len_t'(n + `JVS_CHECKSUM_SIZE);
        sum = node + len;
        enc_q.delete();
        enc_q.push_back(`JVS_SYNC);
        push_escaped(node);
        push_escaped(len);
        for (int j = 0; j < n; j++) begin
            push_escaped(frame_data[j]);
            sum = sum + frame_data[j];
        end
        push_escaped(corrupt ? sum + 8'd1 : sum);
    endtask

    ////////////////////
    // TX path
    ////////////////////

    task automatic run_tx(input jvs_pkg::jvs_byte_t node, input int n);
        encode_frame(node, n, 1'b0);
        got_q.delete();
        for (int j = 0; j < n; j++) begin
            @(posedge clk_sys);
            i_tx_push <= 1'b1;
            i_tx_data <= frame_data[j];
        end
        @(posedge clk_sys);
        i_tx_push   <= 1'b0;
        i_tx_commit <= 1'b1;
        i_dst_node  <= node;
        @(posedge clk_sys);
        i_tx_commit <= 1'b0;
        i_tx_push   <= 1'b1;  // Ready is low, byte must never show up
        i_tx_data   <= 8'h5A;
        @(posedge clk_sys) i_tx_push <= 1'b0;
        @(negedge clk_sys);
        while (!o_tx_ready) @(negedge clk_sys);
        if (got_q.size() != enc_q.size())
            report_failure($sformatf("TX frame had %0d bytes instead of %0d",
                                     got_q.size(), enc_q.size()));
        foreach (enc_q[i]) check_byte("o_uart_tx_byte", enc_q[i], got_q[i]);
    endtask

    // UART transmitter model, done after a random delay
    initial begin
        int delay;
        forever begin
            @(negedge clk_sys);
            if (o_uart_tx_valid) begin
                delay = rand_bits(3);
                repeat (delay) @(posedge clk_sys);
                @(posedge clk_sys) i_uart_tx_done <= 1'b1;
                @(posedge clk_sys) i_uart_tx_done <= 1'b0;
            end
        end
    end

    // Byte capture and RS485 timing, sampled mid cycle
    always @(negedge clk_sys) begin
        if (!reset) begin
            if (o_tx_ready == o_rs485_dir) report_failure("o_tx_ready and o_rs485_dir overlap");
            if (o_rs485_dir && !dir_q) begin
                rise_cyc   = cyc;
                first_byte = 1'b1;
            end
            // Done is taken by the DUT one edge after it shows here
            if (!o_rs485_dir && dir_q && (cyc - done_cyc != `JVS_RS485_HOLD_CYCLES + 2))
                report_failure($sformatf("o_rs485_dir fell %0d cycles after the last done",
                                         cyc - done_cyc - 1));
            if (i_uart_tx_done) done_cyc = cyc;
            if (o_uart_tx_valid) begin
                if (!o_rs485_dir) report_failure("Byte sent with o_rs485_dir low");
                if (first_byte && (cyc - rise_cyc != `JVS_RS485_SETUP_CYCLES + 1))
                    report_failure($sformatf("First byte came %0d cycles after o_rs485_dir rose",
                                             cyc - rise_cyc));
                if (!first_byte && (cyc - done_cyc != 2))
                    report_failure("Next byte did not follow done by 2 cycles");
                first_byte = 1'b0;
                got_q.push_back(o_uart_tx_byte);
            end
            dir_q = o_rs485_dir;
        end
    end

    ////////////////////
    // RX path
    ////////////////////

    task automatic send_stream();
        foreach (enc_q[i]) begin
            @(posedge clk_sys);
            i_uart_rx_valid <= 1'b1;
            i_uart_rx_byte  <= enc_q[i];
            @(negedge clk_sys);
            if (o_rx_complete || o_rx_error) report_failure("Frame result before its checksum");
        end
        @(posedge clk_sys) i_uart_rx_valid <= 1'b0;
    endtask

    task automatic run_rx(input jvs_pkg::jvs_byte_t node, input int n, input logic bad);
        jvs_pkg::jvs_len_t errs;
        errs = o_checksum_errors;
        encode_frame(node, n, bad);
        send_stream();
        // Checksum byte was taken at the last edge, result shows three edges later
        for (int k = 1; k <= 4; k++) begin
            @(negedge clk_sys);
            if (k < 4 && (o_rx_complete || o_rx_error)) report_failure("Frame result too early");
        end
        if (bad) begin
            if (!o_rx_error || o_rx_complete) report_failure("Bad checksum gave no lone error");
            check_count("o_checksum_errors", errs + 8'd1, o_checksum_errors);
        end else begin
            if (!o_rx_complete || o_rx_error) report_failure("Good frame gave no o_rx_complete");
            check_count("o_checksum_errors", errs, o_checksum_errors);
            check_status("o_rx_status", jvs_pkg::jvs_status_e'(frame_data[0]), o_rx_status);
            check_byte("o_rx_src_node", node, o_rx_src_node);
            for (int j = 1; j < n; j++) begin
                check_byte("o_rx_byte", frame_data[j], o_rx_byte);
                check_count("o_rx_remaining", jvs_pkg::jvs_len_t'(n - 1 - j), o_rx_remaining);
                if (j < n - 1) begin
                    @(posedge clk_sys) i_rx_next <= 1'b1;
                    @(posedge clk_sys) i_rx_next <= 1'b0;
                    @(negedge clk_sys);
                end
            end
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
        report_failure($sformatf("Timeout, still running after %0d cycles", WATCHDOG_CYCLES));
    end

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        jvs_pkg::jvs_byte_t node;
        int                 n;
        logic               bad;
        i_tx_data       = '0;
        i_dst_node      = '0;
        i_tx_push       = 1'b0;
        i_tx_commit     = 1'b0;
        i_uart_tx_done  = 1'b0;
        i_uart_rx_valid = 1'b0;
        i_uart_rx_byte  = '0;
        i_rx_next       = 1'b0;
        lfsr            = 16'd10;
        stim_tab[0] = {8'h00, 8'h01, 8'd4, 8'h01, 8'hE0, 8'hD0, 8'h33}; // Escaped data
        stim_tab[1] = {8'h00, 8'hE0, 8'd6, 8'h01, 8'h11, 8'h22, 8'hD0}; // Node is E0
        stim_tab[2] = {8'h00, 8'hD0, 8'd3, 8'h02, 8'hD0, 8'hE0, 8'h00}; // Node is D0
        stim_tab[3] = {8'h01, 8'h05, 8'd6, 8'h01, 8'hAA, 8'hE0, 8'h55}; // Corrupt checksum
        stim_tab[4] = {8'h00, 8'h10, 8'd3, 8'h01, 8'hC0, 8'h0B, 8'h00}; // Checksum is E0
        stim_tab[5] = {8'h00, 8'h21, 8'hCF, 8'h05, 8'hE0, 8'hD0, 8'h44}; // Length is D0
        stim_tab[6] = {8'h00, 8'h20, 8'd3, 8'h03, 8'hA0, 8'h09, 8'h00}; // Checksum is D0
        reset = 1'b1;
        repeat (5) @(posedge clk_sys);
        reset <= 1'b0;
        @(negedge clk_sys);
        if (!o_tx_ready || o_rs485_dir || o_uart_tx_valid || o_rx_complete || o_rx_error)
            report_failure("Control outputs wrong after reset");
        check_count("o_checksum_errors", 8'd0, o_checksum_errors);
        check_count("o_rx_remaining", 8'd0, o_rx_remaining);

        for (int e = 0; e < N_ENTRIES; e++) begin
            build_frame(e, node, n, bad);
            run_tx(node, n);
            run_rx(node, n, bad);
        end

        // Frame cut by a new sync while an escape is pending
        enc_q = '{`JVS_SYNC, 8'h09, 8'h05, 8'h01, `JVS_ESCAPE};
        send_stream();
        build_frame(0, node, n, bad);
        run_rx(node, n, bad);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: jvs_link.f
+incdir+rtl
rtl/jvs_pkg.sv
rtl/jvs_rx_unescape.sv
rtl/jvs_rx_frame.sv
rtl/jvs_rx_buffer.sv
rtl/jvs_tx_frame.sv
rtl/jvs_link.sv
tb/tb_jvs_link.sv

// File: Bender.yml
package:
  name: jvs_link

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/jvs_pkg.sv
      - rtl/jvs_rx_unescape.sv
      - rtl/jvs_rx_frame.sv
      - rtl/jvs_rx_buffer.sv
      - rtl/jvs_tx_frame.sv
      - rtl/jvs_link.sv
      - target: simulation
        files:
          - tb/tb_jvs_link.sv
